// ==== mem_stage.f ====
+incdir+rtl
rtl/mem_stage_pkg.sv
rtl/mem_pma.sv
rtl/mem_req_tracker.sv
rtl/dcache_dm.sv
rtl/load_align.sv
rtl/mmio_regs.sv
rtl/mem_stage.sv
sim/wb_mem_model.sv
sim/tb_mem_stage.sv

// ==== Bender.yml ====
package:
  name: mem_stage

export_include_dirs:
  - rtl

sources:
  - rtl/mem_stage_pkg.sv
  - rtl/mem_pma.sv
  - rtl/mem_req_tracker.sv
  - rtl/dcache_dm.sv
  - rtl/load_align.sv
  - rtl/mmio_regs.sv
  - rtl/mem_stage.sv
  - target: simulation
    files:
      - sim/wb_mem_model.sv
      - sim/tb_mem_stage.sv

// ==== sim/tb_mem_stage.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mem_stage_cfg.svh"

module tb_mem_stage
  import mem_stage_pkg::*;
();

  localparam logic [31:0] ADDR_A       = 32'h0000_0140;
  localparam logic [31:0] ADDR_B       = 32'h0000_2008;
  localparam logic [31:0] ADDR_U       = `MS_UNCACHED_BASE + 32'h40;
  localparam logic [31:0] REG_GPIO_OUT = `MS_MMIO_BASE;
  localparam logic [31:0] REG_GPIO_IN  = `MS_MMIO_BASE + 32'h4;
  localparam logic [31:0] REG_SCRATCH  = `MS_MMIO_BASE + 32'h8;
  localparam logic [31:0] REG_NONE     = `MS_MMIO_BASE + 32'hC;
  localparam int          TIMEOUT_CYCLES = 64;

  logic        clk_i;
  logic        reset_i;
  logic        flush_i;
  mem_req_t    req;
  logic        stall;
  logic        done;
  logic [31:0] load_data;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic [7:0]  gpio_in;
  logic [7:0]  gpio_out;
  logic [3:0]  ack_delay;
  logic [31:0] ack_count;

  int errors         = 0;
  int monitor_errors = 0;
  int tests_run      = 0;
  int tests_failed   = 0;

  // expected memory contents keyed by word-aligned address
  logic [31:0] shadow [bit [31:0]];

  // results of the last access
  logic [31:0] rd;
  int          lat;
  int          xfers;

  mem_stage u_mem_stage (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .flush_i    (flush_i),
    .req_i      (req),
    .stall_o    (stall),
    .done_o     (done),
    .load_data_o(load_data),
    .wb_req_o   (wb_req),
    .wb_rsp_i   (wb_rsp),
    .gpio_i     (gpio_in),
    .gpio_o     (gpio_out)
  );

  wb_mem_model u_wb_mem (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .wb_req_i   (wb_req),
    .wb_rsp_o   (wb_rsp),
    .ack_delay_i(ack_delay),
    .ack_count_o(ack_count)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // wishbone classic rules sampled mid-cycle
  wb_req_t prev_wb_req;
  logic    prev_pending;
  logic    prev_acked;

  always @(negedge clk_i) begin
    if (reset_i) begin
      prev_pending = 1'b0;
      prev_acked   = 1'b0;
    end else begin
      if (wb_req.cyc != wb_req.stb) begin
        $display("ERROR @%0t: wishbone cyc and stb differ", $time);
        monitor_errors++;
      end
      if (prev_pending && wb_req.cyc && (wb_req !== prev_wb_req)) begin
        $display("ERROR @%0t: wishbone request changed before ack", $time);
        monitor_errors++;
      end
      if (prev_acked && wb_req.cyc) begin
        $display("ERROR @%0t: wishbone cyc still high the cycle after ack", $time);
        monitor_errors++;
      end
      prev_pending = wb_req.cyc && !wb_rsp.ack;
      prev_acked   = wb_req.cyc && wb_rsp.ack;
    end
    prev_wb_req = wb_req;
  end

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR @%0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("ERROR @%0t: %s got %0d expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_at_start);
    tests_run++;
    if (errors + monitor_errors != errs_at_start) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic preload(input logic [31:0] addr, input logic [31:0] data);
    shadow[{addr[31:2], 2'b00}] = data;
    u_wb_mem.preload_word(addr, data);
  endtask

  // size and sign rule for loads on the lane at the address offset
  function automatic logic [31:0] extend_load(input logic [31:0] word, input logic [1:0] off,
                                              input mem_size_e size, input logic sign);
    logic [31:0] shifted;
    shifted = word >> (8 * off);
    if (size == MEM_BYTE) begin
      return (sign && shifted[7]) ? (shifted | 32'hFFFF_FF00) : (shifted & 32'h0000_00FF);
    end
    if (size == MEM_HALF) begin
      return (sign && shifted[15]) ? (shifted | 32'hFFFF_0000) : (shifted & 32'h0000_FFFF);
    end
    return word;
  endfunction

  // starts and ends 1 ns after a rising edge; lat counts cycles from fire to done
  task automatic run_access(
    input  logic [31:0] addr,
    input  logic        we,
    input  mem_size_e   size,
    input  logic        sign,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output int          cycles,
    output int          transfers
  );
    logic [31:0] acks_before;
    logic        is_mmio;
    logic        finished;
    acks_before = ack_count;
    is_mmio     = (addr >= `MS_MMIO_BASE);
    rdata       = '0;
    cycles      = 0;
    finished    = 1'b0;
    req.valid   = 1'b1;
    req.addr    = addr;
    req.we      = we;
    req.size    = size;
    req.sign    = sign;
    req.wdata   = wdata;
    #4;
    while (!finished && cycles <= TIMEOUT_CYCLES) begin
      if (done) begin
        finished = 1'b1;
        rdata    = load_data;
        if (stall) begin
          $display("ERROR @%0t: stall_o high together with done_o at %h", $time, addr);
          errors++;
        end
      end else begin
        if (is_mmio || !stall) begin
          $display("ERROR @%0t: stall_o is %b while access to %h is open", $time, stall, addr);
          errors++;
        end
        @(posedge clk_i);
        #5;
        cycles++;
      end
    end
    if (!finished) begin
      $display("timeout: access to %h got no done_o within %0d cycles", addr, TIMEOUT_CYCLES);
      errors++;
    end
    next_cycle();
    req.valid = 1'b0;
    #4;
    if (finished && done) begin
      $display("ERROR @%0t: done_o held longer than one cycle at %h", $time, addr);
      errors++;
    end
    next_cycle();
    transfers = ack_count - acks_before;
  endtask

  task automatic test_reset();
    int errs_at_start;
    errs_at_start = errors + monitor_errors;
    #4;
    check_value("stall_o after reset", {31'b0, stall}, 32'h0);
    check_value("done_o after reset", {31'b0, done}, 32'h0);
    check_value("wishbone cyc after reset", {31'b0, wb_req.cyc}, 32'h0);
    check_value("gpio_o after reset", {24'b0, gpio_out}, 32'h0);
    next_cycle();
    run_access(REG_SCRATCH, 1'b0, MEM_WORD, 1'b0, '0, rd, lat, xfers);
    check_value("scratch after reset", rd, 32'h0);
    check_count("bus transfers on register read", xfers, 0);
    finish_test("reset state", errs_at_start);
  endtask

  task automatic test_miss_then_hit();
    int errs_at_start;
    errs_at_start = errors + monitor_errors;
    preload(ADDR_A, $urandom);
    run_access(ADDR_A, 1'b0, MEM_WORD, 1'b0, '0, rd, lat, xfers);
    check_value("load on miss", rd, shadow[ADDR_A]);
    check_count("bus transfers on miss", xfers, 1);
    run_access(ADDR_A, 1'b0, MEM_WORD, 1'b0, '0, rd, lat, xfers);
    check_value("load on hit", rd, shadow[ADDR_A]);
    check_count("bus transfers on hit", xfers, 0);
    check_count("hit latency", lat, 1);
    finish_test("cacheable miss then hit", errs_at_start);
  endtask

  task automatic test_subword_loads();
    int errs_at_start;
    errs_at_start = errors + monitor_errors;
    // lanes 1 and 2 and the low half negative, the rest positive
    preload(ADDR_B, ($urandom & 32'h7F7F_7F7F) | 32'h0080_8000);
    run_access(ADDR_B, 1'b0, MEM_WORD, 1'b0, '0, rd, lat, xfers);
    check_value("word load before lane tests", rd, shadow[ADDR_B]);
    check_count("bus transfers on fill", xfers, 1);
    for (int off = 0; off < 4; off++) begin
      for (int s = 0; s < 2; s++) begin
        run_access(ADDR_B + off, 1'b0, MEM_BYTE, s[0], '0, rd, lat, xfers);
        check_value($sformatf("byte load offset %0d sign %0d", off, s), rd,
                    extend_load(shadow[ADDR_B], off[1:0], MEM_BYTE, s[0]));
        check_count("bus transfers on byte hit", xfers, 0);
      end
    end
    for (int off = 0; off < 4; off += 2) begin
      for (int s = 0; s < 2; s++) begin
        run_access(ADDR_B + off, 1'b0, MEM_HALF, s[0], '0, rd, lat, xfers);
        check_value($sformatf("half load offset %0d sign %0d", off, s), rd,
                    extend_load(shadow[ADDR_B], off[1:0], MEM_HALF, s[0]));
        check_count("bus transfers on half hit", xfers, 0);
      end
    end
    finish_test("byte and half loads", errs_at_start);
  endtask

  task automatic test_store_merge();
    int          errs_at_start;
    logic [31:0] wdata;
    logic [31:0] merged;
    errs_at_start = errors + monitor_errors;
    // upper bits are junk since only the low byte is stored
    wdata          = $urandom;
    merged         = shadow[ADDR_A];
    merged[23:16]  = wdata[7:0];
    shadow[ADDR_A] = merged;
    run_access(ADDR_A + 2, 1'b1, MEM_BYTE, 1'b0, wdata, rd, lat, xfers);
    check_count("bus transfers on byte store", xfers, 1);
    check_value("memory word after byte store", u_wb_mem.fetch_word(ADDR_A), shadow[ADDR_A]);
    run_access(ADDR_A, 1'b0, MEM_WORD, 1'b0, '0, rd, lat, xfers);
    check_value("load after store hit", rd, shadow[ADDR_A]);
    check_count("bus transfers on load after store", xfers, 0);
    check_count("hit latency after store", lat, 1);
    finish_test("store write-through and merge", errs_at_start);
  endtask

  task automatic test_uncached_and_flush();
    int errs_at_start;
    errs_at_start = errors + monitor_errors;
    preload(ADDR_U, $urandom);
    for (int d = 0; d < 9; d += 3) begin
      ack_delay = d[3:0];
      run_access(ADDR_U, 1'b0, MEM_WORD, 1'b0, '0, rd, lat, xfers);
      check_value($sformatf("uncached load with ack delay %0d", d), rd, shadow[ADDR_U]);
      check_count("bus transfers on uncached load", xfers, 1);
      // cyc one cycle after fire, ack after the delay, response one cycle after ack
      check_count("uncached load latency", lat, d + 3);
    end
    ack_delay = '0;
    // the uncached loads use the line index of ADDR_A and must leave that line cached
    run_access(ADDR_A, 1'b0, MEM_WORD, 1'b0, '0, rd, lat, xfers);
    check_value("load before flush", rd, shadow[ADDR_A]);
    check_count("bus transfers before flush", xfers, 0);
    flush_i = 1'b1;
    next_cycle();
    flush_i = 1'b0;
    run_access(ADDR_A, 1'b0, MEM_WORD, 1'b0, '0, rd, lat, xfers);
    check_value("load after flush", rd, shadow[ADDR_A]);
    check_count("bus transfers after flush", xfers, 1);
    run_access(ADDR_A, 1'b0, MEM_WORD, 1'b0, '0, rd, lat, xfers);
    check_count("bus transfers on refilled line", xfers, 0);
    finish_test("uncached loads and flush", errs_at_start);
  endtask

  task automatic test_registers();
    int          errs_at_start;
    logic [31:0] wdata;
    logic [7:0]  pins;
    errs_at_start = errors + monitor_errors;
    wdata = $urandom;
    run_access(REG_GPIO_OUT, 1'b1, MEM_BYTE, 1'b0, wdata, rd, lat, xfers);
    check_value("gpio_o after write", {24'b0, gpio_out}, {24'b0, wdata[7:0]});
    check_count("gpio write latency", lat, 0);
    check_count("bus transfers on gpio write", xfers, 0);
    run_access(REG_GPIO_OUT, 1'b0, MEM_WORD, 1'b0, '0, rd, lat, xfers);
    check_value("gpio_out read back", rd, {24'b0, wdata[7:0]});
    pins    = $urandom;
    gpio_in = pins;
    // three edges for a synchronizer that needs two
    repeat (3) next_cycle();
    run_access(REG_GPIO_IN, 1'b0, MEM_WORD, 1'b0, '0, rd, lat, xfers);
    check_value("gpio_in read", rd, {24'b0, pins});
    check_count("bus transfers on gpio read", xfers, 0);
    wdata = $urandom;
    run_access(REG_SCRATCH, 1'b1, MEM_WORD, 1'b0, wdata, rd, lat, xfers);
    check_count("bus transfers on scratch write", xfers, 0);
    run_access(REG_SCRATCH, 1'b0, MEM_WORD, 1'b0, '0, rd, lat, xfers);
    check_value("scratch read back", rd, wdata);
    check_count("scratch read latency", lat, 0);
    run_access(REG_NONE, 1'b0, MEM_WORD, 1'b0, '0, rd, lat, xfers);
    check_value("unused register read", rd, 32'h0);
    finish_test("register space", errs_at_start);
  endtask

  initial begin
    int unsigned seed_value;
    seed_value = $urandom(32'h3a24);
    reset_i    = 1'b1;
    flush_i    = 1'b0;
    req        = '0;
    req.size   = MEM_WORD;
    gpio_in    = '0;
    ack_delay  = '0;
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    test_reset();
    test_miss_then_hit();
    test_subword_loads();
    test_store_merge();
    test_uncached_and_flush();
    test_registers();

    $display("tests run: %0d, failed: %0d, check errors: %0d",
             tests_run, tests_failed, errors + monitor_errors);
    if ((errors + monitor_errors == 0) && (tests_failed == 0)) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/wb_mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mem_stage_cfg.svh"

module wb_mem_model
  import mem_stage_pkg::*;
(
  input  logic                clk_i,
  input  logic                reset_i,
  input  wb_req_t             wb_req_i,
  output wb_rsp_t             wb_rsp_o,
  input  logic [3:0]          ack_delay_i,
  output logic [`MS_XLEN-1:0] ack_count_o
);

  // sparse word store keyed by word address
  logic [`MS_XLEN-1:0] mem [bit [`MS_XLEN-3:0]];
  logic                ack_q = 1'b0;
  logic [`MS_XLEN-1:0] dat_q = '0;
  logic [3:0]          wait_q;
  logic [`MS_XLEN-1:0] merged;

  // words never written read back as a pattern of their whole address
  function automatic logic [`MS_XLEN-1:0] fetch_word(input logic [`MS_XLEN-1:0] addr);
    if (mem.exists(addr[`MS_XLEN-1:2])) begin
      return mem[addr[`MS_XLEN-1:2]];
    end
    return ({addr[`MS_XLEN-1:2], 2'b00} * 32'h9E37_79B1) ^ 32'h1357_9BDF;
  endfunction

  task automatic preload_word(input logic [`MS_XLEN-1:0] addr, input logic [`MS_XLEN-1:0] data);
    mem[addr[`MS_XLEN-1:2]] = data;
  endtask

  // one ack per transfer after ack_delay_i extra cycles
  always @(posedge clk_i) begin
    if (reset_i) begin
      ack_q       <= 1'b0;
      dat_q       <= '0;
      wait_q      <= '0;
      ack_count_o <= '0;
    end else begin
      ack_q <= 1'b0;
      if (wb_req_i.cyc && wb_req_i.stb && !ack_q) begin
        if (wait_q >= ack_delay_i) begin
          ack_q       <= 1'b1;
          wait_q      <= '0;
          ack_count_o <= ack_count_o + 1;
          if (wb_req_i.we) begin
            merged = fetch_word(wb_req_i.adr);
            for (int b = 0; b < `MS_BYTES; b++) begin
              if (wb_req_i.sel[b]) begin
                merged[8*b +: 8] = wb_req_i.dat[8*b +: 8];
              end
            end
            mem[wb_req_i.adr[`MS_XLEN-1:2]] = merged;
          end else begin
            dat_q <= fetch_word(wb_req_i.adr);
          end
        end else begin
          wait_q <= wait_q + 1;
        end
      end else begin
        wait_q <= '0;
      end
    end
  end

  always_comb begin
    wb_rsp_o.ack = ack_q;
    wb_rsp_o.dat = dat_q;
  end

endmodule

`default_nettype wire

// ==== rtl/mem_stage.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mem_stage_cfg.svh"

module mem_stage
  import mem_stage_pkg::*;
(
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                flush_i,
  input  mem_req_t            req_i,
  output logic                stall_o,
  output logic                done_o,
  output logic [`MS_XLEN-1:0] load_data_o,
  output wb_req_t             wb_req_o,
  input  wb_rsp_t             wb_rsp_i,
  input  logic [7:0]          gpio_i,
  output logic [7:0]          gpio_o
);

  mem_region_e          region;
  mem_req_t             req_lane;
  dc_req_t              dc_req;
  dc_rsp_t              dc_rsp;
  logic                 mmio_fire;
  logic [`MS_BYTES-1:0] sel;
  logic [`MS_XLEN-1:0]  store_wdata;
  logic [`MS_XLEN-1:0]  mmio_rdata;
  logic [`MS_XLEN-1:0]  rd_word;
  logic [`MS_XLEN-1:0]  align_word;

  assign rd_word = (region == REGION_MMIO) ? mmio_rdata : dc_rsp.rdata;

  // a store has no read word, so its data goes through the aligner instead
  assign align_word = req_i.we ? req_i.wdata : rd_word;

  // same request with the store data moved onto its byte lanes
  always_comb begin
    req_lane       = req_i;
    req_lane.wdata = store_wdata;
  end

  mem_pma u_pma (
    .addr_i  (req_i.addr),
    .region_o(region)
  );

  mem_req_tracker u_tracker (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .flush_i       (flush_i),
    .req_i         (req_lane),
    .region_i      (region),
    .sel_i         (sel),
    .dc_rsp_valid_i(dc_rsp.valid),
    .dc_req_o      (dc_req),
    .mmio_fire_o   (mmio_fire),
    .stall_o       (stall_o),
    .done_o        (done_o)
  );

  dcache_dm u_dcache (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .flush_i (flush_i),
    .dc_req_i(dc_req),
    .dc_rsp_o(dc_rsp),
    .wb_req_o(wb_req_o),
    .wb_rsp_i(wb_rsp_i)
  );

  load_align u_align (
    .addr_i (req_i.addr[1:0]),
    .size_i (req_i.size),
    .sign_i (req_i.sign),
    .word_i (align_word),
    .data_o (load_data_o),
    .sel_o  (sel),
    .wdata_o(store_wdata)
  );

  mmio_regs u_mmio (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .fire_i (mmio_fire),
    .we_i   (req_i.we),
    .addr_i (req_i.addr[3:2]),
    .sel_i  (sel),
    .wdata_i(store_wdata),
    .rdata_o(mmio_rdata),
    .gpio_i (gpio_i),
    .gpio_o (gpio_o)
  );

endmodule

`default_nettype wire

// ==== rtl/mmio_regs.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mem_stage_cfg.svh"

module mmio_regs
  import mem_stage_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 fire_i,
  input  logic                 we_i,
  input  logic [1:0]           addr_i,
  input  logic [`MS_BYTES-1:0] sel_i,
  input  logic [`MS_XLEN-1:0]  wdata_i,
  output logic [`MS_XLEN-1:0]  rdata_o,
  input  logic [7:0]           gpio_i,
  output logic [7:0]           gpio_o
);

  localparam logic [1:0] REG_GPIO_OUT = 2'd0;
  localparam logic [1:0] REG_GPIO_IN  = 2'd1;
  localparam logic [1:0] REG_SCRATCH  = 2'd2;

  logic [7:0]          gpio_out_q;
  logic [7:0]          gpio_meta_q;
  logic [7:0]          gpio_sync_q;
  logic [`MS_XLEN-1:0] scratch_q;

  // writes to the read-only gpio_in are dropped
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpio_out_q <= '0;
      scratch_q  <= '0;
    end else if (fire_i && we_i) begin
      if ((addr_i == REG_GPIO_OUT) && sel_i[0]) begin
        gpio_out_q <= wdata_i[7:0];
      end
      if (addr_i == REG_SCRATCH) begin
        for (int b = 0; b < `MS_BYTES; b++) begin
          if (sel_i[b]) begin
            scratch_q[8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  // two-flop synchronizer for the asynchronous pins
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpio_meta_q <= '0;
      gpio_sync_q <= '0;
    end else begin
      gpio_meta_q <= gpio_i;
      gpio_sync_q <= gpio_meta_q;
    end
  end

  always_comb begin
    unique case (addr_i)
      REG_GPIO_OUT: rdata_o = {24'b0, gpio_out_q};
      REG_GPIO_IN:  rdata_o = {24'b0, gpio_sync_q};
      REG_SCRATCH:  rdata_o = scratch_q;
      default:      rdata_o = '0;
    endcase
  end

  assign gpio_o = gpio_out_q;

endmodule

`default_nettype wire

// ==== rtl/load_align.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mem_stage_cfg.svh"

module load_align
  import mem_stage_pkg::*;
(
  input  logic [1:0]           addr_i,
  input  mem_size_e            size_i,
  input  logic                 sign_i,
  input  logic [`MS_XLEN-1:0]  word_i,
  output logic [`MS_XLEN-1:0]  data_o,
  output logic [`MS_BYTES-1:0] sel_o,
  output logic [`MS_XLEN-1:0]  wdata_o
);

  logic [7:0]  byte_lane;
  logic [15:0] half_lane;

  assign byte_lane = word_i[{addr_i, 3'b000} +: 8];
  assign half_lane = word_i[{addr_i[1], 4'b0000} +: 16];

  always_comb begin
    unique case (size_i)
      MEM_BYTE: begin
        data_o  = sign_i ? {{24{byte_lane[7]}}, byte_lane} : {24'b0, byte_lane};
        sel_o   = 4'b0001 << addr_i;
        wdata_o = {4{word_i[7:0]}};
      end
      MEM_HALF: begin
        data_o  = sign_i ? {{16{half_lane[15]}}, half_lane} : {16'b0, half_lane};
        sel_o   = addr_i[1] ? 4'b1100 : 4'b0011;
        wdata_o = {2{word_i[15:0]}};
      end
      // word, and anything unexpected treated as word
      default: begin
        data_o  = word_i;
        sel_o   = 4'b1111;
        wdata_o = word_i;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/dcache_dm.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mem_stage_cfg.svh"

module dcache_dm
  import mem_stage_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    flush_i,
  input  dc_req_t dc_req_i,
  output dc_rsp_t dc_rsp_o,
  output wb_req_t wb_req_o,
  input  wb_rsp_t wb_rsp_i
);

  localparam int IDX_W = $clog2(`MS_DC_LINES);
  localparam int TAG_W = `MS_XLEN - IDX_W - 2;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_BUS,
    ST_RESPOND
  } dc_state_e;

  dc_state_e               state_q;
  dc_state_e               state_d;
  dc_req_t                 req_q;
  logic [`MS_XLEN-1:0]     rdata_q;
  logic [`MS_DC_LINES-1:0] line_valid_q;
  logic [TAG_W-1:0]        tag_mem [`MS_DC_LINES];
  logic [`MS_XLEN-1:0]     data_mem [`MS_DC_LINES];

  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] tag;
  logic             hit;
  logic             load_hit;
  logic             bus_active;
  logic             wb_done;

  // all lookups work on the latched request
  assign idx = req_q.addr[IDX_W+1:2];
  assign tag = req_q.addr[`MS_XLEN-1:IDX_W+2];

  assign hit        = line_valid_q[idx] && (tag_mem[idx] == tag) && !req_q.uncached;
  assign load_hit   = hit && !req_q.we;
  // misses, stores and uncached accesses go out on the bus from lookup on
  assign bus_active = ((state_q == ST_LOOKUP) && !load_hit) || (state_q == ST_BUS);
  assign wb_done    = bus_active && wb_rsp_i.ack;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (dc_req_i.valid) begin
          state_d = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        if (load_hit) begin
          state_d = ST_IDLE;
        end else if (wb_rsp_i.ack) begin
          state_d = ST_RESPOND;
        end else begin
          state_d = ST_BUS;
        end
      end
      ST_BUS: begin
        if (wb_rsp_i.ack) begin
          state_d = ST_RESPOND;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == ST_IDLE) && dc_req_i.valid) begin
      req_q <= dc_req_i;
    end
    if (wb_done) begin
      rdata_q <= wb_rsp_i.dat;
    end
  end

  // only a cacheable load refill makes a line valid
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      line_valid_q <= '0;
    end else if (wb_done && !req_q.uncached && !req_q.we) begin
      line_valid_q[idx] <= 1'b1;
    end
  end

  // refill on load miss, byte merge on store hit, no allocate on store miss
  always_ff @(posedge clk_i) begin
    if (wb_done && !req_q.uncached) begin
      if (!req_q.we) begin
        tag_mem[idx]  <= tag;
        data_mem[idx] <= wb_rsp_i.dat;
      end else if (hit) begin
        for (int b = 0; b < `MS_BYTES; b++) begin
          if (req_q.sel[b]) begin
            data_mem[idx][8*b +: 8] <= req_q.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  always_comb begin
    dc_rsp_o.valid = ((state_q == ST_LOOKUP) && load_hit) || (state_q == ST_RESPOND);
    dc_rsp_o.rdata = (state_q == ST_RESPOND) ? rdata_q : data_mem[idx];
  end

  // bus fields come straight from req_q, so they hold until ack
  always_comb begin
    wb_req_o.cyc = bus_active;
    wb_req_o.stb = bus_active;
    wb_req_o.we  = req_q.we;
    wb_req_o.adr = {req_q.addr[`MS_XLEN-1:2], 2'b00};
    wb_req_o.dat = req_q.wdata;
    // loads always fetch the full word
    wb_req_o.sel = req_q.we ? req_q.sel : '1;
  end

endmodule

`default_nettype wire

// ==== rtl/mem_req_tracker.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mem_stage_cfg.svh"

module mem_req_tracker
  import mem_stage_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 flush_i,
  input  mem_req_t             req_i,
  input  mem_region_e          region_i,
  input  logic [`MS_BYTES-1:0] sel_i,
  input  logic                 dc_rsp_valid_i,
  output dc_req_t              dc_req_o,
  output logic                 mmio_fire_o,
  output logic                 stall_o,
  output logic                 done_o
);

  logic                valid_q;
  logic [`MS_XLEN-1:0] addr_q;
  logic                we_q;
  mem_size_e           size_q;
  logic                open_q;
  logic                req_changed;
  logic                fire;
  logic                mem_fire;

  // copy of last cycle's request, used to spot a new one
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_q <= 1'b0;
      addr_q  <= '0;
      we_q    <= 1'b0;
      size_q  <= MEM_WORD;
    end else begin
      valid_q <= req_i.valid;
      addr_q  <= req_i.addr;
      we_q    <= req_i.we;
      size_q  <= req_i.size;
    end
  end

  // wdata is left out since it depends on forwarding, which depends on stall_o
  assign req_changed = (req_i.valid && !valid_q) || (req_i.addr != addr_q) ||
                       (req_i.we != we_q) || (req_i.size != size_q);
  assign fire        = req_i.valid && req_changed && !open_q && !flush_i;
  assign mem_fire    = fire && (region_i != REGION_MMIO);
  assign mmio_fire_o = fire && (region_i == REGION_MMIO);

  // open from the fire until the cache answers
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      open_q <= 1'b0;
    end else if (mem_fire) begin
      open_q <= 1'b1;
    end else if (dc_rsp_valid_i) begin
      open_q <= 1'b0;
    end
  end

  always_comb begin
    dc_req_o.valid    = mem_fire;
    dc_req_o.addr     = req_i.addr;
    dc_req_o.we       = req_i.we;
    dc_req_o.sel      = sel_i;
    dc_req_o.wdata    = req_i.wdata;
    dc_req_o.uncached = (region_i == REGION_UNCACHED);
  end

  assign stall_o = mem_fire || (open_q && !dc_rsp_valid_i);
  assign done_o  = (open_q && dc_rsp_valid_i) || mmio_fire_o;

endmodule

`default_nettype wire

// ==== rtl/mem_pma.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mem_stage_cfg.svh"

module mem_pma
  import mem_stage_pkg::*;
(
  input  logic [`MS_XLEN-1:0] addr_i,
  output mem_region_e         region_o
);

  // the regions are contiguous, so two compares against the bases are enough
  always_comb begin
    if (addr_i < `MS_UNCACHED_BASE) begin
      region_o = REGION_CACHED;
    end else if (addr_i < `MS_MMIO_BASE) begin
      region_o = REGION_UNCACHED;
    end else begin
      region_o = REGION_MMIO;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mem_stage_pkg.sv ====
`default_nettype none
`include "mem_stage_cfg.svh"

package mem_stage_pkg;

  // access size as encoded by the execute stage
  typedef enum logic [1:0] {
    MEM_BYTE = 2'b01,
    MEM_HALF = 2'b10,
    MEM_WORD = 2'b11
  } mem_size_e;

  typedef enum logic [1:0] {
    REGION_CACHED   = 2'd0,
    REGION_UNCACHED = 2'd1,
    REGION_MMIO     = 2'd2
  } mem_region_e;

  // request from the execute stage with wdata not yet aligned
  typedef struct packed {
    logic                valid;
    logic [`MS_XLEN-1:0] addr;
    logic                we;
    mem_size_e           size;
    logic                sign;
    logic [`MS_XLEN-1:0] wdata;
  } mem_req_t;

  // request into the data cache with wdata already placed on its lanes
  typedef struct packed {
    logic                 valid;
    logic [`MS_XLEN-1:0]  addr;
    logic                 we;
    logic [`MS_BYTES-1:0] sel;
    logic [`MS_XLEN-1:0]  wdata;
    logic                 uncached;
  } dc_req_t;

  typedef struct packed {
    logic                valid;
    logic [`MS_XLEN-1:0] rdata;
  } dc_rsp_t;

  // wishbone classic master outputs
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [`MS_XLEN-1:0]  adr;
    logic [`MS_XLEN-1:0]  dat;
    logic [`MS_BYTES-1:0] sel;
  } wb_req_t;

  typedef struct packed {
    logic                ack;
    logic [`MS_XLEN-1:0] dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/mem_stage_cfg.svh ====
`ifndef MEM_STAGE_CFG_SVH
`define MEM_STAGE_CFG_SVH

// data and address width
`define MS_XLEN 32

// byte lanes per word
`define MS_BYTES (`MS_XLEN / 8)

// one word per line, direct mapped, index taken from addr[5:2]
`define MS_DC_LINES 16

// address map
// below the uncached base is cacheable memory
`define MS_UNCACHED_BASE 32'h8000_0000

// register space from here to the top
`define MS_MMIO_BASE 32'hF000_0000

`endif
